//--- verilog/rv_core_pkg.sv
/*
  rv_core shared definitions
  register and instruction widths, rv64i integer opcode and funct
  encodings, and the alu operation set used by decode and execute
*/
package rv_core_pkg;

  // register width
  localparam int xlen = 64;

  // shift amount width for rv64
  localparam int shamt_w = 6;

  typedef logic [xlen-1:0] xlen_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [31:0]     instr_t;

  // major opcodes handled by the core
  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_lui    = 7'b0110111;

  // funct3 codes shared by op and op-imm
  localparam logic [2:0] funct3_add_sub = 3'b000;
  localparam logic [2:0] funct3_sll     = 3'b001;
  localparam logic [2:0] funct3_slt     = 3'b010;
  localparam logic [2:0] funct3_sltu    = 3'b011;
  localparam logic [2:0] funct3_xor     = 3'b100;
  localparam logic [2:0] funct3_srl_sra = 3'b101;
  localparam logic [2:0] funct3_or      = 3'b110;
  localparam logic [2:0] funct3_and     = 3'b111;

  // selects sub in place of add, sra in place of srl
  localparam logic [6:0] funct7_alt = 7'b0100000;

  // alu operation carried from decode to execute
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    // lui, result is the immediate itself
    alu_pass
  } alu_op_t;

endpackage

//--- verilog/rv_decode.sv
/*
  rv_core decode stage
  accepts instruction words over valid/ready, splits the fields,
  builds the immediate and registers the decoded alu operation
*/
`timescale 1ns/1ps

module rv_decode (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   instr_valid,
  input  rv_core_pkg::instr_t    instr,
  output logic                   instr_ready,
  output logic                   dec_valid,
  input  logic                   dec_ready,
  output rv_core_pkg::alu_op_t   dec_op,
  output rv_core_pkg::reg_addr_t dec_rd,
  output rv_core_pkg::reg_addr_t dec_rs1,
  output rv_core_pkg::reg_addr_t dec_rs2,
  output rv_core_pkg::xlen_t     dec_imm,
  output logic                   dec_use_imm,
  output logic                   dec_writes_rd,
  output logic                   dec_illegal
);

  logic [6:0]           opcode;
  logic [2:0]           funct3;
  logic [6:0]           funct7;
  rv_core_pkg::xlen_t   i_imm;
  rv_core_pkg::xlen_t   shamt_imm;
  rv_core_pkg::xlen_t   u_imm;
  rv_core_pkg::alu_op_t op_next;
  rv_core_pkg::xlen_t   imm_next;
  logic                 use_imm_next;
  logic                 writes_rd_next;
  logic                 illegal_next;

  // funct3 to operation, alt picks sub/sra
  function automatic rv_core_pkg::alu_op_t map_funct3(input logic [2:0] f3, input logic alt);
    rv_core_pkg::alu_op_t op;
    case (f3)
      rv_core_pkg::funct3_add_sub: op = alt ? rv_core_pkg::alu_sub : rv_core_pkg::alu_add;
      rv_core_pkg::funct3_sll:     op = rv_core_pkg::alu_sll;
      rv_core_pkg::funct3_slt:     op = rv_core_pkg::alu_slt;
      rv_core_pkg::funct3_sltu:    op = rv_core_pkg::alu_sltu;
      rv_core_pkg::funct3_xor:     op = rv_core_pkg::alu_xor;
      rv_core_pkg::funct3_srl_sra: op = alt ? rv_core_pkg::alu_sra : rv_core_pkg::alu_srl;
      rv_core_pkg::funct3_or:      op = rv_core_pkg::alu_or;
      default:                     op = rv_core_pkg::alu_and;
    endcase
    return op;
  endfunction

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign i_imm     = {{52{instr[31]}}, instr[31:20]};
  assign shamt_imm = {{(rv_core_pkg::xlen - rv_core_pkg::shamt_w){1'b0}},
                      instr[20 +: rv_core_pkg::shamt_w]};
  assign u_imm     = {{32{instr[31]}}, instr[31:12], 12'b0};

  always_comb begin
    op_next        = rv_core_pkg::alu_add;
    imm_next       = i_imm;
    use_imm_next   = 1'b1;
    writes_rd_next = 1'b1;
    illegal_next   = 1'b0;
    case (opcode)
      rv_core_pkg::opcode_op: begin
        use_imm_next = 1'b0;
        op_next      = map_funct3(funct3, funct7 == rv_core_pkg::funct7_alt);
      end
      rv_core_pkg::opcode_op_imm: begin
        // no subi, alt only matters for the right shift
        op_next = map_funct3(funct3, funct3 == rv_core_pkg::funct3_srl_sra &&
                                     instr[30]);
        if (funct3 == rv_core_pkg::funct3_sll || funct3 == rv_core_pkg::funct3_srl_sra) begin
          imm_next = shamt_imm;
        end
      end
      rv_core_pkg::opcode_lui: begin
        op_next  = rv_core_pkg::alu_pass;
        imm_next = u_imm;
      end
      default: begin
        writes_rd_next = 1'b0;
        illegal_next   = 1'b1;
      end
    endcase
  end

  // stage accepts when empty or draining
  assign instr_ready = !dec_valid || dec_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      dec_valid <= 1'b0;
    end else if (instr_ready) begin
      dec_valid <= instr_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (instr_valid && instr_ready) begin
      dec_op        <= op_next;
      dec_rd        <= instr[11:7];
      dec_rs1       <= instr[19:15];
      dec_rs2       <= instr[24:20];
      dec_imm       <= imm_next;
      dec_use_imm   <= use_imm_next;
      dec_writes_rd <= writes_rd_next;
      dec_illegal   <= illegal_next;
    end
  end

endmodule

//--- verilog/rv_execute.sv
/*
  rv_core execute stage
  reads operands with forwarding from the retiring item and computes
  the 64-bit alu result, passed on combinationally to the result stage
*/
`timescale 1ns/1ps

module rv_execute (
  input  logic                   dec_valid,
  output logic                   dec_ready,
  input  rv_core_pkg::alu_op_t   dec_op,
  input  rv_core_pkg::reg_addr_t dec_rd,
  input  rv_core_pkg::reg_addr_t dec_rs1,
  input  rv_core_pkg::reg_addr_t dec_rs2,
  input  rv_core_pkg::xlen_t     dec_imm,
  input  logic                   dec_use_imm,
  input  logic                   dec_writes_rd,
  input  logic                   dec_illegal,
  output rv_core_pkg::reg_addr_t rs1_addr,
  output rv_core_pkg::reg_addr_t rs2_addr,
  input  rv_core_pkg::xlen_t     rs1_data,
  input  rv_core_pkg::xlen_t     rs2_data,
  input  logic                   fwd_valid,
  input  rv_core_pkg::reg_addr_t fwd_rd,
  input  rv_core_pkg::xlen_t     fwd_data,
  output logic                   exe_valid,
  input  logic                   exe_ready,
  output rv_core_pkg::reg_addr_t exe_rd,
  output rv_core_pkg::xlen_t     exe_data,
  output logic                   exe_writes_rd,
  output logic                   exe_illegal
);

  rv_core_pkg::xlen_t                src1;
  rv_core_pkg::xlen_t                src2;
  rv_core_pkg::xlen_t                op1;
  rv_core_pkg::xlen_t                op2;
  logic [rv_core_pkg::shamt_w-1:0]   shamt;
  rv_core_pkg::xlen_t                alu_out;

  assign rs1_addr = dec_rs1;
  assign rs2_addr = dec_rs2;

  // held item has not reached the register file yet
  assign src1 = (fwd_valid && fwd_rd == dec_rs1) ? fwd_data : rs1_data;
  assign src2 = (fwd_valid && fwd_rd == dec_rs2) ? fwd_data : rs2_data;

  assign op1   = src1;
  assign op2   = dec_use_imm ? dec_imm : src2;
  assign shamt = op2[rv_core_pkg::shamt_w-1:0];

  always_comb begin
    case (dec_op)
      rv_core_pkg::alu_add:  alu_out = op1 + op2;
      rv_core_pkg::alu_sub:  alu_out = op1 - op2;
      rv_core_pkg::alu_sll:  alu_out = op1 << shamt;
      rv_core_pkg::alu_slt: begin
        alu_out = {{(rv_core_pkg::xlen - 1){1'b0}}, $signed(op1) < $signed(op2)};
      end
      rv_core_pkg::alu_sltu: begin
        alu_out = {{(rv_core_pkg::xlen - 1){1'b0}}, op1 < op2};
      end
      rv_core_pkg::alu_xor:  alu_out = op1 ^ op2;
      rv_core_pkg::alu_srl:  alu_out = op1 >> shamt;
      rv_core_pkg::alu_sra:  alu_out = $unsigned($signed(op1) >>> shamt);
      rv_core_pkg::alu_or:   alu_out = op1 | op2;
      rv_core_pkg::alu_and:  alu_out = op1 & op2;
      default:               alu_out = op2;
    endcase
  end

  // no state here, item moves straight into the result register
  assign dec_ready     = exe_ready;
  assign exe_valid     = dec_valid;
  assign exe_rd        = dec_rd;
  assign exe_data      = alu_out;
  assign exe_writes_rd = dec_writes_rd;
  assign exe_illegal   = dec_illegal;

endmodule

//--- verilog/rv_result.sv
/*
  rv_core result stage
  holds the retiring item, drives the retire handshake, commits the
  register write and exposes the pending write for forwarding
*/
`timescale 1ns/1ps

module rv_result (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   exe_valid,
  output logic                   exe_ready,
  input  rv_core_pkg::reg_addr_t exe_rd,
  input  rv_core_pkg::xlen_t     exe_data,
  input  logic                   exe_writes_rd,
  input  logic                   exe_illegal,
  output logic                   retire_valid,
  input  logic                   retire_ready,
  output rv_core_pkg::reg_addr_t retire_rd,
  output rv_core_pkg::xlen_t     retire_data,
  output logic                   retire_illegal,
  output logic                   wr_en,
  output rv_core_pkg::reg_addr_t wr_addr,
  output rv_core_pkg::xlen_t     wr_data,
  output logic                   fwd_valid,
  output rv_core_pkg::reg_addr_t fwd_rd,
  output rv_core_pkg::xlen_t     fwd_data
);

  logic writes_rd_q;

  assign exe_ready = !retire_valid || retire_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      retire_valid <= 1'b0;
    end else if (exe_ready) begin
      retire_valid <= exe_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (exe_valid && exe_ready) begin
      retire_rd      <= exe_rd;
      retire_data    <= exe_data;
      retire_illegal <= exe_illegal;
      writes_rd_q    <= exe_writes_rd;
    end
  end

  // x0 writes retire but never land
  assign fwd_valid = retire_valid && writes_rd_q && (retire_rd != '0);
  assign fwd_rd    = retire_rd;
  assign fwd_data  = retire_data;

  assign wr_en   = fwd_valid && retire_ready;
  assign wr_addr = retire_rd;
  assign wr_data = retire_data;

endmodule

//--- verilog/rv_regfile.sv
/*
  rv_core register file
  32 x 64-bit, one write port and two combinational read ports
*/
`timescale 1ns/1ps

module rv_regfile (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   wr_en,
  input  rv_core_pkg::reg_addr_t wr_addr,
  input  rv_core_pkg::xlen_t     wr_data,
  input  rv_core_pkg::reg_addr_t rd_addr1,
  input  rv_core_pkg::reg_addr_t rd_addr2,
  output rv_core_pkg::xlen_t     rd_data1,
  output rv_core_pkg::xlen_t     rd_data2
);

  rv_core_pkg::xlen_t regs [32];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // x0 hardwired
  assign rd_data1 = (rd_addr1 == '0) ? '0 : regs[rd_addr1];
  assign rd_data2 = (rd_addr2 == '0) ? '0 : regs[rd_addr2];

endmodule

//--- verilog/rv_core.sv
/*
  rv_core top level
  rv64 integer pipeline: decode, execute and result stages around a
  register file, with valid/ready on the instruction and retire ports
*/
`timescale 1ns/1ps

module rv_core (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   instr_valid,
  output logic                   instr_ready,
  input  rv_core_pkg::instr_t    instr,
  output logic                   retire_valid,
  input  logic                   retire_ready,
  output rv_core_pkg::reg_addr_t retire_rd,
  output rv_core_pkg::xlen_t     retire_data,
  output logic                   retire_illegal
);

  logic                   dec_valid;
  logic                   dec_ready;
  rv_core_pkg::alu_op_t   dec_op;
  rv_core_pkg::reg_addr_t dec_rd;
  rv_core_pkg::reg_addr_t dec_rs1;
  rv_core_pkg::reg_addr_t dec_rs2;
  rv_core_pkg::xlen_t     dec_imm;
  logic                   dec_use_imm;
  logic                   dec_writes_rd;
  logic                   dec_illegal;

  rv_core_pkg::reg_addr_t rs1_addr;
  rv_core_pkg::reg_addr_t rs2_addr;
  rv_core_pkg::xlen_t     rs1_data;
  rv_core_pkg::xlen_t     rs2_data;

  logic                   exe_valid;
  logic                   exe_ready;
  rv_core_pkg::reg_addr_t exe_rd;
  rv_core_pkg::xlen_t     exe_data;
  logic                   exe_writes_rd;
  logic                   exe_illegal;

  logic                   wr_en;
  rv_core_pkg::reg_addr_t wr_addr;
  rv_core_pkg::xlen_t     wr_data;
  logic                   fwd_valid;
  rv_core_pkg::reg_addr_t fwd_rd;
  rv_core_pkg::xlen_t     fwd_data;

  rv_decode decode_i (
    .clock         (clock),
    .reset         (reset),
    .instr_valid   (instr_valid),
    .instr         (instr),
    .instr_ready   (instr_ready),
    .dec_valid     (dec_valid),
    .dec_ready     (dec_ready),
    .dec_op        (dec_op),
    .dec_rd        (dec_rd),
    .dec_rs1       (dec_rs1),
    .dec_rs2       (dec_rs2),
    .dec_imm       (dec_imm),
    .dec_use_imm   (dec_use_imm),
    .dec_writes_rd (dec_writes_rd),
    .dec_illegal   (dec_illegal)
  );

  rv_execute execute_i (
    .dec_valid     (dec_valid),
    .dec_ready     (dec_ready),
    .dec_op        (dec_op),
    .dec_rd        (dec_rd),
    .dec_rs1       (dec_rs1),
    .dec_rs2       (dec_rs2),
    .dec_imm       (dec_imm),
    .dec_use_imm   (dec_use_imm),
    .dec_writes_rd (dec_writes_rd),
    .dec_illegal   (dec_illegal),
    .rs1_addr      (rs1_addr),
    .rs2_addr      (rs2_addr),
    .rs1_data      (rs1_data),
    .rs2_data      (rs2_data),
    .fwd_valid     (fwd_valid),
    .fwd_rd        (fwd_rd),
    .fwd_data      (fwd_data),
    .exe_valid     (exe_valid),
    .exe_ready     (exe_ready),
    .exe_rd        (exe_rd),
    .exe_data      (exe_data),
    .exe_writes_rd (exe_writes_rd),
    .exe_illegal   (exe_illegal)
  );

  rv_result result_i (
    .clock          (clock),
    .reset          (reset),
    .exe_valid      (exe_valid),
    .exe_ready      (exe_ready),
    .exe_rd         (exe_rd),
    .exe_data       (exe_data),
    .exe_writes_rd  (exe_writes_rd),
    .exe_illegal    (exe_illegal),
    .retire_valid   (retire_valid),
    .retire_ready   (retire_ready),
    .retire_rd      (retire_rd),
    .retire_data    (retire_data),
    .retire_illegal (retire_illegal),
    .wr_en          (wr_en),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data),
    .fwd_valid      (fwd_valid),
    .fwd_rd         (fwd_rd),
    .fwd_data       (fwd_data)
  );

  rv_regfile regfile_i (
    .clock    (clock),
    .reset    (reset),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_addr1 (rs1_addr),
    .rd_addr2 (rs2_addr),
    .rd_data1 (rs1_data),
    .rd_data2 (rs2_data)
  );

endmodule

//--- dv/rv_core_assert.sv
/*
  rv_core handshake assertions
  bound to the core top level, checks both valid/ready ports
*/
`timescale 1ns/1ps

module rv_core_assert (
  input logic                   clock,
  input logic                   reset,
  input logic                   instr_valid,
  input logic                   instr_ready,
  input rv_core_pkg::instr_t    instr,
  input logic                   retire_valid,
  input logic                   retire_ready,
  input rv_core_pkg::reg_addr_t retire_rd,
  input rv_core_pkg::xlen_t     retire_data,
  input logic                   retire_illegal
);

  // stalled retire keeps its item
  assert property (@(posedge clock) disable iff (reset)
    retire_valid && !retire_ready |=> retire_valid && $stable(retire_rd) &&
    $stable(retire_data) && $stable(retire_illegal))
  else $error("retire fields changed while retire_ready was low");

  assert property (@(posedge clock) !reset |-> !$isunknown(retire_valid))
  else $error("retire_valid is unknown out of reset");

  // source side rule on the instruction port
  assert property (@(posedge clock) disable iff (reset)
    instr_valid && !instr_ready |=> $stable(instr))
  else $error("instr changed while waiting for instr_ready");

endmodule

bind rv_core rv_core_assert rv_core_assert_i (.*);

//--- dv/rv_core_tb.sv
/*
  rv_core testbench
  feeds a table of rv64 integer instructions twice and checks every retire
  in order, first with retire_ready held high, then under random back-pressure
*/
`timescale 1ns/1ps

module rv_core_tb;

  localparam int timeout_cycles = 50;

  logic                   clock;
  logic                   reset;
  logic                   instr_valid;
  logic                   instr_ready;
  rv_core_pkg::instr_t    instr;
  logic                   retire_valid;
  logic                   retire_ready;
  rv_core_pkg::reg_addr_t retire_rd;
  rv_core_pkg::xlen_t     retire_data;
  logic                   retire_illegal;

  rv_core_pkg::instr_t    row_instr[$];
  rv_core_pkg::reg_addr_t row_rd[$];
  rv_core_pkg::xlen_t     row_data[$];
  logic                   row_illegal[$];

  logic [31:0] lfsr = 32'h9192_9feb;
  logic        random_ready = 1'b0;
  int          cur_row = 0;
  int          mismatches = 0;
  int          failures = 0;

  rv_core rv_core_i (
    .clock          (clock),
    .reset          (reset),
    .instr_valid    (instr_valid),
    .instr_ready    (instr_ready),
    .instr          (instr),
    .retire_valid   (retire_valid),
    .retire_ready   (retire_ready),
    .retire_rd      (retire_rd),
    .retire_data    (retire_data),
    .retire_illegal (retire_illegal)
  );

  // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  function automatic rv_core_pkg::instr_t encode_imm(input logic [2:0] f3,
      input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic rv_core_pkg::instr_t encode_reg(input logic [6:0] f7,
      input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  task automatic add_row(input rv_core_pkg::instr_t word, input rv_core_pkg::reg_addr_t rd,
                         input rv_core_pkg::xlen_t data, input logic illegal);
    row_instr.push_back(word);
    row_rd.push_back(rd);
    row_data.push_back(data);
    row_illegal.push_back(illegal);
  endtask

  task automatic build_table();
    // op-imm and lui from all registers at zero
    add_row(encode_imm(3'b000, 1, 0, 12'h005), 1, 64'h5, 0);
    add_row(encode_imm(3'b000, 2, 0, 12'hffd), 2, 64'hffff_ffff_ffff_fffd, 0);
    add_row(encode_imm(3'b100, 3, 1, 12'h00f), 3, 64'ha, 0);
    add_row(encode_imm(3'b110, 4, 1, 12'h030), 4, 64'h35, 0);
    add_row(encode_imm(3'b111, 5, 2, 12'h0f0), 5, 64'hf0, 0);
    add_row(encode_imm(3'b010, 6, 2, 12'h001), 6, 64'h1, 0);
    add_row(encode_imm(3'b011, 7, 2, 12'h001), 7, 64'h0, 0);
    add_row(encode_imm(3'b011, 8, 1, 12'hfff), 8, 64'h1, 0);
    add_row({20'h80000, 5'd9, 7'b0110111}, 9, 64'hffff_ffff_8000_0000, 0);
    add_row({20'h12345, 5'd10, 7'b0110111}, 10, 64'h1234_5000, 0);
    // register-register group
    add_row(encode_reg(7'h00, 3'b000, 11, 1, 2), 11, 64'h2, 0);
    add_row(encode_reg(7'h20, 3'b000, 12, 1, 2), 12, 64'h8, 0);
    add_row(encode_reg(7'h00, 3'b001, 13, 1, 3), 13, 64'h1400, 0);
    add_row(encode_reg(7'h00, 3'b101, 14, 9, 1), 14, 64'h07ff_ffff_fc00_0000, 0);
    add_row(encode_reg(7'h20, 3'b101, 15, 9, 1), 15, 64'hffff_ffff_fc00_0000, 0);
    add_row(encode_reg(7'h00, 3'b010, 16, 2, 1), 16, 64'h1, 0);
    add_row(encode_reg(7'h00, 3'b011, 17, 2, 1), 17, 64'h0, 0);
    add_row(encode_reg(7'h00, 3'b100, 18, 1, 3), 18, 64'hf, 0);
    add_row(encode_reg(7'h00, 3'b110, 19, 10, 1), 19, 64'h1234_5005, 0);
    add_row(encode_reg(7'h00, 3'b111, 20, 2, 10), 20, 64'h1234_5000, 0);
    // dependent chain through the forward path
    add_row(encode_imm(3'b000, 21, 0, 12'h001), 21, 64'h1, 0);
    add_row(encode_reg(7'h00, 3'b000, 21, 21, 21), 21, 64'h2, 0);
    add_row(encode_imm(3'b001, 22, 21, 12'h004), 22, 64'h20, 0);
    add_row(encode_imm(3'b101, 23, 2, 12'h401), 23, 64'hffff_ffff_ffff_fffe, 0);
    // x0 write then read
    add_row(encode_imm(3'b000, 0, 1, 12'h007), 0, 64'hc, 0);
    add_row(encode_reg(7'h00, 3'b000, 24, 0, 1), 24, 64'h5, 0);
    // load opcode is illegal and leaves x1 alone
    add_row({12'h000, 5'd0, 3'b011, 5'd1, 7'b0000011}, 1, 64'h0, 1);
    add_row(encode_imm(3'b000, 25, 1, 12'h000), 25, 64'h5, 0);
    // x1 again once the illegal item has left the pipeline
    add_row(encode_imm(3'b000, 26, 1, 12'h000), 26, 64'h5, 0);
  endtask

  task automatic check_data(input string name, input rv_core_pkg::xlen_t got,
                            input rv_core_pkg::xlen_t expected);
    if (got !== expected) begin
      mismatches++;
      $display("mismatch %s row %0d: got %h, expected %h", name, cur_row, got, expected);
    end
  endtask

  task automatic check_rd(input string name, input rv_core_pkg::reg_addr_t got,
                          input rv_core_pkg::reg_addr_t expected);
    if (got !== expected) begin
      mismatches++;
      $display("mismatch %s row %0d: got %h, expected %h", name, cur_row, got, expected);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      mismatches++;
      $display("mismatch %s row %0d: got %h, expected %h", name, cur_row, got, expected);
    end
  endtask

  task automatic drive_rows();
    int waited;
    for (int n = 0; n < 2 * row_instr.size(); n++) begin
      @(posedge clock);
      instr_valid <= 1'b1;
      instr       <= row_instr[n % row_instr.size()];
      waited = 0;
      @(negedge clock);
      while (!instr_ready && waited < timeout_cycles) begin
        @(negedge clock);
        waited++;
      end
      if (!instr_ready) begin
        failures++;
        $display("instr_ready stayed low for row %0d", n % row_instr.size());
        return;
      end
      // second pass runs under back-pressure
      if (n == row_instr.size() - 1) begin
        random_ready = 1'b1;
      end
    end
    @(posedge clock);
    instr_valid <= 1'b0;
  endtask

  task automatic check_rows();
    int   waited;
    logic bubble;
    for (int n = 0; n < 2 * row_instr.size(); n++) begin
      cur_row = n % row_instr.size();
      waited = 0;
      bubble = 1'b0;
      @(negedge clock);
      while (!(retire_valid && retire_ready) && waited < timeout_cycles) begin
        if (n > 0 && !retire_valid) begin
          bubble = 1'b1;
        end
        @(negedge clock);
        waited++;
      end
      if (!(retire_valid && retire_ready)) begin
        failures++;
        $display("no retire seen for row %0d", cur_row);
        return;
      end
      // rows are offered every cycle so the retire stream never empties
      if (bubble) begin
        failures++;
        $display("retire port went empty before row %0d", cur_row);
      end
      check_flag("retire_illegal", retire_illegal, row_illegal[cur_row]);
      if (!row_illegal[cur_row]) begin
        check_rd("retire_rd", retire_rd, row_rd[cur_row]);
        check_data("retire_data", retire_data, row_data[cur_row]);
      end
    end
  endtask

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  initial begin
    forever begin
      @(posedge clock);
      if (random_ready) begin
        lfsr = lfsr_step(lfsr);
        retire_ready <= lfsr[0];
      end else begin
        retire_ready <= 1'b1;
      end
    end
  end

  initial begin
    reset        = 1'b1;
    instr_valid  = 1'b0;
    instr        = '0;
    retire_ready = 1'b0;
    build_table();
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    fork
      drive_rows();
      check_rows();
    join
    // nothing may retire beyond the table
    repeat (4) begin
      @(negedge clock);
      if (retire_valid) begin
        failures++;
        $display("extra item on the retire port after the last row");
      end
    end
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
verilog/rv_core_pkg.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_result.sv
verilog/rv_regfile.sv
verilog/rv_core.sv
dv/rv_core_assert.sv
dv/rv_core_tb.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - verilog/rv_core_pkg.sv
  - verilog/rv_decode.sv
  - verilog/rv_execute.sv
  - verilog/rv_result.sv
  - verilog/rv_regfile.sv
  - verilog/rv_core.sv
  - target: simulation
    files:
      - dv/rv_core_assert.sv
      - dv/rv_core_tb.sv
